// File: src/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// cache geometry
`define DC_WAYS 4
`define DC_SETS 16
// 128-bit rows per 64-byte line
`define DC_ROWS 4

// a refill burst moves one line as 64-bit beats
`define DC_BEATS 8

// size of the backing memory in doublewords
`define MEM_WORDS 4096

`endif

// File: src/dcache_pkg.sv
package dcache_pkg;

	// address fields for 16 sets of 64-byte lines in 128-bit rows
	typedef struct packed {
		logic [21:0] tag;
		logic [3:0]  set;
		logic [1:0]  row;
		logic        half;
		logic [2:0]  byte_off;
	} cache_addr_t;

	typedef union packed {
		logic [31:0] raw;
		cache_addr_t f;
	} cache_addr_u;

	// requester bundle, held until ready
	typedef struct packed {
		logic        valid;
		logic        wren;
		cache_addr_u addr;
		logic [63:0] din;
		logic [7:0]  strb;
	} cache_req_t;

	// write-through port, addr counts doublewords
	typedef struct packed {
		logic        en;
		logic [28:0] addr;
		logic [63:0] data;
		logic [7:0]  strb;
	} mem_wr_t;

	typedef struct packed {
		logic        arvalid;
		logic [31:0] araddr;
	} mem_ar_t;

	typedef struct packed {
		logic        rvalid;
		logic [63:0] rdata;
		logic        rlast;
	} mem_r_t;

endpackage

// File: src/dcache_tag_array.sv
`timescale 1ns/1ns
`include "dcache_config.svh"

module dcache_tag_array import dcache_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	input  cache_addr_u         addr,
	output logic [`DC_WAYS-1:0] hit,
	input  logic                fill_en,
	input  logic [`DC_WAYS-1:0] fill_way,
	input  logic                inval
);

	logic [21:0]          tags [`DC_WAYS][`DC_SETS];
	logic [`DC_SETS-1:0]  valid_bits [`DC_WAYS];
	logic [`DC_WAYS-1:0]  tag_match;

	// all ways of the addressed set are compared at once
	always_comb begin
		for (int w = 0; w < `DC_WAYS; w++) begin
			tag_match[w] = (tags[w][addr.f.set] == addr.f.tag);
			hit[w] = valid_bits[w][addr.f.set] && tag_match[w];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < `DC_WAYS; w++) begin
				valid_bits[w] <= '0;
			end
		end else begin
			for (int w = 0; w < `DC_WAYS; w++) begin
				if (fill_en && fill_way[w]) begin
					valid_bits[w][addr.f.set] <= 1'b1;
				end else if (inval && hit[w]) begin
					// written line may be cached, drop it
					valid_bits[w][addr.f.set] <= 1'b0;
				end
			end
		end
	end

	// tag written together with its valid bit at the end of a refill
	always_ff @(posedge clk) begin
		for (int w = 0; w < `DC_WAYS; w++) begin
			if (fill_en && fill_way[w]) begin
				tags[w][addr.f.set] <= addr.f.tag;
			end
		end
	end

endmodule

// File: src/dcache_data_ram.sv
`timescale 1ns/1ns
`include "dcache_config.svh"

// one way of line data, behaves like a single-port SRAM macro
module dcache_data_ram (
	input  logic         clk,
	input  logic         cen,
	input  logic         wen,
	input  logic [127:0] bwen,
	input  logic [5:0]   row,
	input  logic [127:0] wdata,
	output logic [127:0] rdata
);

	logic [127:0] mem [`DC_SETS * `DC_ROWS];

	always_ff @(posedge clk) begin
		if (!cen) begin
			if (!wen) begin
				// a low bwen bit lets the new data through
				mem[row] <= (mem[row] & bwen) | (wdata & ~bwen);
			end else begin
				rdata <= mem[row];
			end
		end
	end

endmodule

// File: src/dcache_ctrl.sv
`timescale 1ns/1ns
`include "dcache_config.svh"

module dcache_ctrl import dcache_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	input  cache_req_t          req,
	output logic                ready,
	output logic [63:0]         dout,
	input  logic [`DC_WAYS-1:0] hit,
	output logic                fill_en,
	output logic [`DC_WAYS-1:0] fill_way,
	output logic                inval,
	output logic [`DC_WAYS-1:0] ram_cen,
	output logic                ram_wen,
	output logic [5:0]          ram_row,
	output logic [127:0]        ram_bwen,
	output logic [127:0]        ram_wdata,
	input  logic [127:0]        ram_rdata0,
	input  logic [127:0]        ram_rdata1,
	input  logic [127:0]        ram_rdata2,
	input  logic [127:0]        ram_rdata3,
	output mem_ar_t             ar,
	input  logic                arready,
	input  mem_r_t              r,
	output mem_wr_t             mem_wr
);

	localparam int BW = $clog2(`DC_BEATS);

	typedef enum logic {idle, refill} state_t;

	state_t              state;
	logic [BW-1:0]       beat;
	logic [`DC_WAYS-1:0] victim;
	logic [`DC_WAYS-1:0] hit_prev;
	logic                take;
	logic                rd_hit;
	logic                rd_miss;
	logic                wr_req;
	logic                beat_in;
	logic [127:0]        line;

	// a held request is served once, never while ready is up
	assign take    = (state == idle) && req.valid && !ready;
	assign wr_req  = take && req.wren;
	assign rd_hit  = take && !req.wren && (hit != '0);
	assign rd_miss = take && !req.wren && (hit == '0);
	assign beat_in = (state == refill) && r.rvalid;

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= idle;
			beat     <= '0;
			victim   <= `DC_WAYS'(1);
			hit_prev <= '0;
			ready    <= 1'b0;
		end else begin
			ready <= rd_hit || wr_req;
			if (rd_hit) begin
				hit_prev <= hit;
			end
			case (state)
				idle: begin
					// rotate the replacement pointer while waiting
					victim <= {victim[`DC_WAYS-2:0], victim[`DC_WAYS-1]};
					beat   <= '0;
					if (rd_miss && arready) begin
						state <= refill;
					end
				end
				refill: begin
					if (r.rvalid) begin
						beat <= beat + 1'b1;
						if (r.rlast) begin
							state <= idle;
						end
					end
				end
			endcase
		end
	end

	// even beats fill the low half of a row, odd beats the high half
	assign ram_cen   = (state == idle) ? ~(hit & {`DC_WAYS{rd_hit}})
	                                   : ~(victim & {`DC_WAYS{r.rvalid}});
	assign ram_wen   = !beat_in;
	assign ram_row   = (state == idle) ? {req.addr.f.set, req.addr.f.row}
	                                   : {req.addr.f.set, beat[BW-1:1]};
	assign ram_bwen  = beat[0] ? {64'h0, {64{1'b1}}} : {{64{1'b1}}, 64'h0};
	assign ram_wdata = {2{r.rdata}};

	assign fill_en  = beat_in && r.rlast;
	assign fill_way = victim;
	assign inval    = wr_req;

	assign ar.arvalid = rd_miss;
	assign ar.araddr  = {req.addr.raw[31:6], 6'b0};

	assign mem_wr.en   = wr_req;
	assign mem_wr.addr = req.addr.raw[31:3];
	assign mem_wr.data = req.din;
	assign mem_wr.strb = req.strb;

	// RAM output lands one cycle after the hit, pick it by last cycle's way
	always_comb begin
		case (hit_prev)
			4'b0010: line = ram_rdata1;
			4'b0100: line = ram_rdata2;
			4'b1000: line = ram_rdata3;
			default: line = ram_rdata0;
		endcase
	end

	assign dout = req.addr.f.half ? line[127:64] : line[63:0];

endmodule

// File: src/axi_burst_mem.sv
`timescale 1ns/1ns
`include "dcache_config.svh"

module axi_burst_mem import dcache_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  mem_ar_t ar,
	output logic    arready,
	output mem_r_t  r,
	input  mem_wr_t wr
);

	localparam int AW = $clog2(`MEM_WORDS);
	localparam int BW = $clog2(`DC_BEATS);

	logic [63:0]   mem [`MEM_WORDS];
	logic          busy;
	logic [AW-1:0] base;
	logic [BW-1:0] cnt;
	logic [AW-1:0] wr_idx;

	assign arready = !busy;
	assign wr_idx  = wr.addr[AW-1:0];

	// word index wraps at the memory size
	assign r.rvalid = busy;
	assign r.rdata  = mem[base + AW'(cnt)];
	assign r.rlast  = busy && (cnt == BW'(`DC_BEATS - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			base <= '0;
			cnt  <= '0;
		end else if (!busy) begin
			if (ar.arvalid) begin
				busy <= 1'b1;
				base <= ar.araddr[3 +: AW];
				cnt  <= '0;
			end
		end else begin
			cnt <= cnt + 1'b1;
			if (r.rlast) begin
				busy <= 1'b0;
			end
		end
	end

	// known pattern at reset so reads can be predicted
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `MEM_WORDS; i++) begin
				mem[i] <= 64'(i) * 64'h0101_0001_0003_0007;
			end
		end else if (wr.en) begin
			for (int b = 0; b < 8; b++) begin
				if (wr.strb[b]) begin
					mem[wr_idx][8*b +: 8] <= wr.data[8*b +: 8];
				end
			end
		end
	end

endmodule

// File: src/dcache_top.sv
`timescale 1ns/1ns
`include "dcache_config.svh"

module dcache_top import dcache_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  cache_req_t  req,
	output logic        ready,
	output logic [63:0] dout
);

	logic [`DC_WAYS-1:0] hit;
	logic [`DC_WAYS-1:0] fill_way;
	logic [`DC_WAYS-1:0] ram_cen;
	logic                fill_en;
	logic                inval;
	logic                ram_wen;
	logic                arready;
	logic [5:0]          ram_row;
	logic [127:0]        ram_bwen;
	logic [127:0]        ram_wdata;
	logic [127:0]        rdata0;
	logic [127:0]        rdata1;
	logic [127:0]        rdata2;
	logic [127:0]        rdata3;
	mem_ar_t             ar;
	mem_r_t              r;
	mem_wr_t             mem_wr;

	dcache_ctrl u_ctrl (
		.clk, .rst, .req, .ready, .dout, .hit,
		.fill_en, .fill_way, .inval,
		.ram_cen, .ram_wen, .ram_row, .ram_bwen, .ram_wdata,
		.ram_rdata0(rdata0), .ram_rdata1(rdata1),
		.ram_rdata2(rdata2), .ram_rdata3(rdata3),
		.ar, .arready, .r, .mem_wr
	);

	// tag lookup uses the held request address directly
	dcache_tag_array u_tags (
		.clk, .rst, .addr(req.addr), .hit, .fill_en, .fill_way, .inval
	);

	dcache_data_ram u_way0 (
		.clk, .cen(ram_cen[0]), .wen(ram_wen), .bwen(ram_bwen),
		.row(ram_row), .wdata(ram_wdata), .rdata(rdata0)
	);

	dcache_data_ram u_way1 (
		.clk, .cen(ram_cen[1]), .wen(ram_wen), .bwen(ram_bwen),
		.row(ram_row), .wdata(ram_wdata), .rdata(rdata1)
	);

	dcache_data_ram u_way2 (
		.clk, .cen(ram_cen[2]), .wen(ram_wen), .bwen(ram_bwen),
		.row(ram_row), .wdata(ram_wdata), .rdata(rdata2)
	);

	dcache_data_ram u_way3 (
		.clk, .cen(ram_cen[3]), .wen(ram_wen), .bwen(ram_bwen),
		.row(ram_row), .wdata(ram_wdata), .rdata(rdata3)
	);

	axi_burst_mem u_mem (
		.clk, .rst, .ar, .arready, .r, .wr(mem_wr)
	);

endmodule

// File: tests/dcache_asserts.sv
`timescale 1ns/1ns
`include "dcache_config.svh"

module dcache_ctrl_asserts import dcache_pkg::*; (
	input logic    clk,
	input logic    rst,
	input logic    ready,
	input logic    state,
	input mem_ar_t ar,
	input logic    arready,
	input mem_r_t  r,
	input logic    fill_en
);

	int fail_count = 0;

	// refill encodes as 1 in the controller state
	logic in_refill;
	assign in_refill = (state == 1'b1);

	a_ready_pulse: assert property (@(posedge clk) disable iff (rst) ready |=> !ready)
		else begin
			fail_count = fail_count + 1;
			$error("ready high for two cycles in a row");
		end

	a_no_ar_in_refill: assert property (@(posedge clk) disable iff (rst) in_refill |-> !ar.arvalid)
		else begin
			fail_count = fail_count + 1;
			$error("arvalid raised during refill");
		end

	// an accepted burst ends with the tag fill on its last beat
	a_fill_after_burst: assert property (@(posedge clk) disable iff (rst)
			(ar.arvalid && arready) |-> ##`DC_BEATS (r.rlast && fill_en))
		else begin
			fail_count = fail_count + 1;
			$error("no fill_en with rlast at the end of an accepted burst");
		end

	a_no_ready_in_refill: assert property (@(posedge clk) disable iff (rst) in_refill |-> !ready)
		else begin
			fail_count = fail_count + 1;
			$error("ready raised during refill");
		end

endmodule

bind dcache_ctrl dcache_ctrl_asserts u_asserts (
	.clk, .rst, .ready, .state, .ar, .arready, .r, .fill_en
);

// File: tests/dcache_tb.sv
`timescale 1ns/1ns
`include "dcache_config.svh"

module dcache_tb import dcache_pkg::*; ();

	localparam int AW = $clog2(`MEM_WORDS);
	// cold reads, offset reads, write pairs, replacement reads, random mix
	localparam int N_REQ = 16 + 32 + 8 + 12 + 400;
	localparam int TIMEOUT_CYCLES = N_REQ * 40 + 5;

	logic        clk;
	logic        rst;
	cache_req_t  req;
	logic        ready;
	logic [63:0] dout;

	logic [63:0] shadow [`MEM_WORDS];
	logic [31:0] seed = 32'h4d6f;

	dcache_top u_dcache_top (
		.clk, .rst, .req, .ready, .dout
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed;
	endfunction

	// memory contents right after reset
	function automatic logic [63:0] reset_word(input int idx);
		return 64'(idx) * 64'h0101_0001_0003_0007;
	endfunction

	function automatic logic [63:0] merge_bytes(input logic [63:0] old, input logic [63:0] data,
			input logic [7:0] strb);
		logic [63:0] res;
		res = old;
		for (int b = 0; b < 8; b++) begin
			if (strb[b]) begin
				res[8*b +: 8] = data[8*b +: 8];
			end
		end
		return res;
	endfunction

	// reference model, a read returns the addressed doubleword
	function automatic logic [63:0] expect_read(input logic [31:0] addr);
		return shadow[addr[3 +: AW]];
	endfunction

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp);
			$display("Simulation finished: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// called on a rising edge, returns on the edge that closes the ready cycle
	task automatic send_req(input logic wren, input logic [31:0] addr, input logic [63:0] din,
			input logic [7:0] strb);
		cache_req_t nxt;
		nxt.valid    = 1'b1;
		nxt.wren     = wren;
		nxt.addr.raw = addr;
		nxt.din      = din;
		nxt.strb     = strb;
		req <= nxt;
		do begin
			@(posedge clk);
		end while (!ready);
	endtask

	task automatic write_then_read(input logic [31:0] addr, input logic [7:0] strb);
		logic [31:0] d_hi;
		logic [31:0] d_lo;
		d_hi = lcg_next();
		d_lo = lcg_next();
		send_req(1'b1, addr, {d_hi, d_lo}, strb);
		send_req(1'b0, addr, 64'h0, 8'h0);
	endtask

	// shadow memory follows each completed write, reads are checked at ready
	initial begin
		for (int i = 0; i < `MEM_WORDS; i++) begin
			shadow[i] = reset_word(i);
		end
		forever begin
			@(posedge clk);
			if (!rst && ready) begin
				if (req.wren) begin
					shadow[req.addr.raw[3 +: AW]] =
						merge_bytes(shadow[req.addr.raw[3 +: AW]], req.din, req.strb);
				end else begin
					check_value("dout", dout, expect_read(req.addr.raw));
				end
			end
		end
	end

	initial begin
		#(TIMEOUT_CYCLES * 8);
		$display("Timeout: ready never came for a pending request");
		$display("Simulation finished: FAIL");
		$fatal(1, "watchdog expired");
	end

	initial begin
		logic [31:0] rnd;
		logic [31:0] d_hi;
		logic [31:0] d_lo;
		logic [31:0] addr;
		rst = 1'b1;
		req = '0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;

		// cold miss in every set
		for (int s = 0; s < 16; s++) begin
			send_req(1'b0, 32'(s) << 6, 64'h0, 8'h0);
		end

		// hits at each row and half of four lines
		for (int s = 0; s < 4; s++) begin
			for (int o = 0; o < 8; o++) begin
				send_req(1'b0, (32'(s) << 6) | (32'(o) << 3), 64'h0, 8'h0);
			end
		end

		// cached lines get invalidated, the last one was never cached
		write_then_read(32'h0000_0060, 8'h0f);
		write_then_read(32'h0000_00b8, 8'hf0);
		write_then_read(32'h0000_00c8, 8'h3c);
		write_then_read(32'h0000_7c48, 8'hff);

		// six tags fight over the four ways of set 5
		for (int pass = 0; pass < 2; pass++) begin
			for (int t = 1; t <= 6; t++) begin
				addr = (32'(t) << 10) | (32'd5 << 6) | (32'(t % 4) << 4);
				send_req(1'b0, addr, 64'h0, 8'h0);
			end
		end

		// eight tags per set keep the hit rate near one half
		for (int i = 0; i < 400; i++) begin
			rnd  = lcg_next();
			addr = {19'b0, rnd[25:16], 3'b0};
			if (rnd[30]) begin
				d_hi = lcg_next();
				d_lo = lcg_next();
				send_req(1'b1, addr, {d_hi, d_lo}, rnd[15:8]);
			end else begin
				send_req(1'b0, addr, 64'h0, 8'h0);
			end
		end

		req.valid <= 1'b0;
		repeat (2) @(posedge clk);
		if (u_dcache_top.u_ctrl.u_asserts.fail_count == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			$display("%0d assertion failures in the controller",
				u_dcache_top.u_ctrl.u_asserts.fail_count);
			$display("Simulation finished: FAIL");
			$fatal(1, "assertion failures");
		end
	end

endmodule

// File: all.f
+incdir+src
src/dcache_pkg.sv
src/dcache_tag_array.sv
src/dcache_data_ram.sv
src/dcache_ctrl.sv
src/axi_burst_mem.sv
src/dcache_top.sv
tests/dcache_asserts.sv
tests/dcache_tb.sv
